//--- rtl/vec_pkg.sv
`default_nettype none

package vec_pkg;

    // operation selector, 2 bits leaves room for more ops
    typedef enum logic [1:0] {
        OP_DOT   = 2'd0,
        OP_CROSS = 2'd1
    } vec_op_t;

    // signed fixed point scalar, Q16.16 by default
    typedef logic signed [31:0] fixed_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    // one queued command, 194 bits
    typedef struct packed {
        vec_op_t op;
        vec3_t   a;
        vec3_t   b;
    } vec_cmd_t;

    // dot results live in value.x, y and z stay zero
    typedef struct packed {
        vec_op_t op;
        vec3_t   value;
    } vec_result_t;

    // control fsm states
    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_WRITE = 1'b1
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] din,
    output logic                  full,
    input  logic                  rd_en,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  empty
);

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

    // extra msb tells a wrapped writer from an equal position
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    // writes while full and reads while empty are dropped
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // first word fall through, head is always on dout
    assign dout = mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage array
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= din;
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_dot.sv
`timescale 1ns/1ps
`default_nettype none

module vec_dot #(
    parameter int Q_BITS = 16
) (
    input  vec_pkg::vec3_t  a,
    input  vec_pkg::vec3_t  b,
    output vec_pkg::fixed_t value
);

    // full width products
    logic signed [63:0] prod_x;
    logic signed [63:0] prod_y;
    logic signed [63:0] prod_z;

    // products back in q format, still wide
    logic signed [63:0] term_x;
    logic signed [63:0] term_y;
    logic signed [63:0] term_z;

    logic signed [63:0] sum;

    assign prod_x = 64'($signed(a.x)) * 64'($signed(b.x));
    assign prod_y = 64'($signed(a.y)) * 64'($signed(b.y));
    assign prod_z = 64'($signed(a.z)) * 64'($signed(b.z));

    assign term_x = prod_x >>> Q_BITS;
    assign term_y = prod_y >>> Q_BITS;
    assign term_z = prod_z >>> Q_BITS;

    assign sum = term_x + term_y + term_z;

    // overflow wraps
    assign value = sum[31:0];

endmodule

`default_nettype wire

//--- rtl/vec_cross.sv
`timescale 1ns/1ps
`default_nettype none

module vec_cross #(
    parameter int Q_BITS = 16
) (
    input  vec_pkg::vec3_t a,
    input  vec_pkg::vec3_t b,
    output vec_pkg::vec3_t value
);

    // products named by operand pair, e.g. yz is a.y * b.z
    logic signed [63:0] prod_yz;
    logic signed [63:0] prod_zy;
    logic signed [63:0] prod_zx;
    logic signed [63:0] prod_xz;
    logic signed [63:0] prod_xy;
    logic signed [63:0] prod_yx;

    logic signed [63:0] diff_x;
    logic signed [63:0] diff_y;
    logic signed [63:0] diff_z;

    assign prod_yz = 64'($signed(a.y)) * 64'($signed(b.z));
    assign prod_zy = 64'($signed(a.z)) * 64'($signed(b.y));
    assign prod_zx = 64'($signed(a.z)) * 64'($signed(b.x));
    assign prod_xz = 64'($signed(a.x)) * 64'($signed(b.z));
    assign prod_xy = 64'($signed(a.x)) * 64'($signed(b.y));
    assign prod_yx = 64'($signed(a.y)) * 64'($signed(b.x));

    // each product is rescaled before the subtraction
    assign diff_x = (prod_yz >>> Q_BITS) - (prod_zy >>> Q_BITS);
    assign diff_y = (prod_zx >>> Q_BITS) - (prod_xz >>> Q_BITS);
    assign diff_z = (prod_xy >>> Q_BITS) - (prod_yx >>> Q_BITS);

    // keep low 32 bits of each element
    assign value.x = diff_x[31:0];
    assign value.y = diff_y[31:0];
    assign value.z = diff_z[31:0];

endmodule

`default_nettype wire

//--- rtl/vec_control.sv
`timescale 1ns/1ps
`default_nettype none

module vec_control (
    input  logic                 clock,
    input  logic                 reset,
    input  vec_pkg::vec_op_t     cmd_op,
    input  logic                 cmd_empty,
    output logic                 cmd_rd_en,
    input  vec_pkg::fixed_t      dot_value,
    input  vec_pkg::vec3_t       cross_value,
    output vec_pkg::vec_result_t result,
    input  logic                 res_full,
    output logic                 res_wr_en
);

    vec_pkg::ctrl_state_t state;
    vec_pkg::ctrl_state_t next_state;

    vec_pkg::vec_result_t result_next;

    // pick the datapath output that matches the head opcode
    always_comb begin
        result_next.op = cmd_op;
        case (cmd_op)
            vec_pkg::OP_DOT: begin
                result_next.value.x = dot_value;
                result_next.value.y = '0;
                result_next.value.z = '0;
            end
            vec_pkg::OP_CROSS: begin
                result_next.value = cross_value;
            end
            default: begin
                // unknown op still gets consumed, value is zero
                result_next.value = '0;
            end
        endcase
    end

    // fsm next state and strobes
    always_comb begin
        next_state = state;
        cmd_rd_en  = 1'b0;
        res_wr_en  = 1'b0;

        case (state)
            vec_pkg::ST_IDLE: begin
                if (!cmd_empty) begin
                    cmd_rd_en  = 1'b1;
                    next_state = vec_pkg::ST_WRITE;
                end
            end
            vec_pkg::ST_WRITE: begin
                // hold here while output fifo is full
                if (!res_full) begin
                    res_wr_en  = 1'b1;
                    next_state = vec_pkg::ST_IDLE;
                end
            end
            default: begin
                next_state = vec_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state  <= vec_pkg::ST_IDLE;
            result <= '0;
        end else begin
            state <= next_state;
            // capture on the pop, head is gone next cycle
            if (cmd_rd_en) begin
                result <= result_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vec_unit #(
    parameter int Q_BITS     = 16,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clock,
    input  logic                 reset,
    input  vec_pkg::vec_cmd_t    cmd_in,
    input  logic                 cmd_wr_en,
    output logic                 cmd_full,
    output vec_pkg::vec_result_t result_out,
    input  logic                 result_rd_en,
    output logic                 result_empty
);

    // command side
    vec_pkg::vec_cmd_t    cmd_head;
    logic                 cmd_empty;
    logic                 cmd_rd_en;

    // datapath outputs
    vec_pkg::fixed_t      dot_value;
    vec_pkg::vec3_t       cross_value;

    // result side
    vec_pkg::vec_result_t result_reg;
    logic                 res_wr_en;
    logic                 res_full;

    fifo #(
        .DATA_WIDTH (($bits(vec_pkg::vec_cmd_t))),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (cmd_wr_en),
        .din   (cmd_in),
        .full  (cmd_full),
        .rd_en (cmd_rd_en),
        .dout  (cmd_head),
        .empty (cmd_empty)
    );

    // both datapaths see the fifo head directly
    vec_dot #(
        .Q_BITS (Q_BITS)
    ) u_vec_dot (
        .a     (cmd_head.a),
        .b     (cmd_head.b),
        .value (dot_value)
    );

    vec_cross #(
        .Q_BITS (Q_BITS)
    ) u_vec_cross (
        .a     (cmd_head.a),
        .b     (cmd_head.b),
        .value (cross_value)
    );

    vec_control u_vec_control (
        .clock       (clock),
        .reset       (reset),
        .cmd_op      (cmd_head.op),
        .cmd_empty   (cmd_empty),
        .cmd_rd_en   (cmd_rd_en),
        .dot_value   (dot_value),
        .cross_value (cross_value),
        .result      (result_reg),
        .res_full    (res_full),
        .res_wr_en   (res_wr_en)
    );

    fifo #(
        .DATA_WIDTH (($bits(vec_pkg::vec_result_t))),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_res_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (res_wr_en),
        .din   (result_reg),
        .full  (res_full),
        .rd_en (result_rd_en),
        .dout  (result_out),
        .empty (result_empty)
    );

endmodule

`default_nettype wire

//--- testbench/vec_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module vec_unit_asserts (
    input logic                 clock,
    input logic                 reset,
    input vec_pkg::ctrl_state_t state,
    input logic                 cmd_empty,
    input logic                 cmd_rd_en,
    input logic                 res_full,
    input logic                 res_wr_en
);

    // never push into a full result fifo
    a_no_write_when_full: assert property (
        @(posedge clock) disable iff (reset) res_wr_en |-> !res_full
    ) else $error("res_wr_en high while res_full is high");

    // never pop an empty command fifo
    a_no_read_when_empty: assert property (
        @(posedge clock) disable iff (reset) cmd_rd_en |-> !cmd_empty
    ) else $error("cmd_rd_en high while cmd_empty is high");

    a_strobes_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(cmd_rd_en && res_wr_en)
    ) else $error("cmd_rd_en and res_wr_en high in the same cycle");

    // first cycle out of reset is quiet and idle
    a_quiet_after_reset: assert property (
        @(posedge clock) $fell(reset) |->
            (!cmd_rd_en && !res_wr_en && state == vec_pkg::ST_IDLE)
    ) else $error("control not idle and quiet in the first cycle after reset");

endmodule

bind vec_control vec_unit_asserts u_vec_unit_asserts (
    .clock     (clock),
    .reset     (reset),
    .state     (state),
    .cmd_empty (cmd_empty),
    .cmd_rd_en (cmd_rd_en),
    .res_full  (res_full),
    .res_wr_en (res_wr_en)
);

`default_nettype wire

//--- testbench/vec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vec_unit_tb;

    localparam int Q_BITS            = 16;
    localparam int FIFO_DEPTH        = 16;
    localparam int TIMEOUT_CYCLES    = 2000;
    localparam int RANDOM_COUNT      = 200;
    localparam int DRAIN_IDLE_CYCLES = 16;

    localparam vec_pkg::fixed_t ONE      = 32'sh0001_0000;
    localparam vec_pkg::fixed_t MOST_NEG = 32'sh8000_0000;
    localparam vec_pkg::fixed_t MOST_POS = 32'sh7fff_ffff;

    logic                 clock;
    logic                 reset;
    vec_pkg::vec_cmd_t    cmd_in;
    logic                 cmd_wr_en;
    logic                 cmd_full;
    vec_pkg::vec_result_t result_out;
    logic                 result_rd_en;
    logic                 result_empty;

    // expected results in write order
    vec_pkg::vec_result_t expected_q[$];

    int error_count;
    int check_count;
    int test_count;
    int failed_tests;
    bit timed_out;

    vec_unit #(
        .Q_BITS     (Q_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clock        (clock),
        .reset        (reset),
        .cmd_in       (cmd_in),
        .cmd_wr_en    (cmd_wr_en),
        .cmd_full     (cmd_full),
        .result_out   (result_out),
        .result_rd_en (result_rd_en),
        .result_empty (result_empty)
    );

    always #10 clock = ~clock;

    // full width product brought back to q format
    function automatic longint scaled_product(input vec_pkg::fixed_t a,
                                              input vec_pkg::fixed_t b);
        longint wide;
        wide = longint'(a) * longint'(b);
        return wide >>> Q_BITS;
    endfunction

    function automatic vec_pkg::vec_result_t model_result(input vec_pkg::vec_cmd_t cmd);
        vec_pkg::vec_result_t r;
        longint ex;
        longint ey;
        longint ez;
        r = '0;
        r.op = cmd.op;
        if (cmd.op == vec_pkg::OP_DOT) begin
            ex = scaled_product(cmd.a.x, cmd.b.x) + scaled_product(cmd.a.y, cmd.b.y)
                 + scaled_product(cmd.a.z, cmd.b.z);
            r.value.x = ex[31:0];
        end else if (cmd.op == vec_pkg::OP_CROSS) begin
            ex = scaled_product(cmd.a.y, cmd.b.z) - scaled_product(cmd.a.z, cmd.b.y);
            ey = scaled_product(cmd.a.z, cmd.b.x) - scaled_product(cmd.a.x, cmd.b.z);
            ez = scaled_product(cmd.a.x, cmd.b.y) - scaled_product(cmd.a.y, cmd.b.x);
            r.value.x = ex[31:0];
            r.value.y = ey[31:0];
            r.value.z = ez[31:0];
        end
        return r;
    endfunction

    function automatic vec_pkg::vec3_t make_vec(input vec_pkg::fixed_t x,
                                                input vec_pkg::fixed_t y,
                                                input vec_pkg::fixed_t z);
        vec_pkg::vec3_t v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    function automatic vec_pkg::vec_cmd_t make_cmd(input vec_pkg::vec_op_t op,
                                                   input vec_pkg::vec3_t a,
                                                   input vec_pkg::vec3_t b);
        vec_pkg::vec_cmd_t c;
        c.op = op;
        c.a = a;
        c.b = b;
        return c;
    endfunction

    // roughly -16.0 to +16.0
    function automatic vec_pkg::fixed_t small_value();
        return vec_pkg::fixed_t'($urandom_range(32'h001f_ffff, 0)) - 32'sh0010_0000;
    endfunction

    function automatic vec_pkg::vec3_t small_vec();
        return make_vec(small_value(), small_value(), small_value());
    endfunction

    function automatic vec_pkg::vec3_t full_vec();
        return make_vec($urandom, $urandom, $urandom);
    endfunction

    function automatic vec_pkg::vec_op_t random_op();
        return ($urandom_range(1, 0) == 0) ? vec_pkg::OP_DOT : vec_pkg::OP_CROSS;
    endfunction

    // called and returns on a falling edge
    task automatic write_command(input vec_pkg::vec_cmd_t cmd);
        int waited;
        waited = 0;
        while (cmd_full && waited < TIMEOUT_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        if (cmd_full) begin
            $display("timeout while waiting for room in the command FIFO");
            error_count++;
            timed_out = 1'b1;
        end else begin
            cmd_in = cmd;
            cmd_wr_en = 1'b1;
            expected_q.push_back(model_result(cmd));
            @(negedge clock);
            cmd_wr_en = 1'b0;
        end
    endtask

    task automatic read_result();
        int waited;
        vec_pkg::vec_result_t got;
        vec_pkg::vec_result_t expected;
        waited = 0;
        while (result_empty && waited < TIMEOUT_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        if (result_empty) begin
            $display("timeout while waiting for a result");
            error_count++;
            timed_out = 1'b1;
        end else begin
            got = result_out;
            if (expected_q.size() == 0) begin
                $display("a result came out with no command left to match it");
                error_count++;
            end else begin
                expected = expected_q.pop_front();
                check_count += 2;
                assert (got.op == expected.op) else begin
                    $display("Fail result_out.op got %h expected %h", got.op, expected.op);
                    error_count++;
                end
                assert (got.value == expected.value) else begin
                    $display("Fail result_out.value got %h expected %h",
                             got.value, expected.value);
                    error_count++;
                end
            end
            result_rd_en = 1'b1;
            @(negedge clock);
            result_rd_en = 1'b0;
        end
    endtask

    task automatic write_and_check(input vec_pkg::vec_cmd_t cmd);
        if (!timed_out) begin
            write_command(cmd);
        end
        if (!timed_out) begin
            read_result();
        end
    endtask

    task automatic check_edge_pair(input vec_pkg::vec3_t a, input vec_pkg::vec3_t b);
        write_and_check(make_cmd(vec_pkg::OP_DOT, a, b));
        write_and_check(make_cmd(vec_pkg::OP_CROSS, a, b));
    endtask

    task automatic edge_value_test();
        vec_pkg::vec3_t zero;
        vec_pkg::vec3_t unit_x;
        vec_pkg::vec3_t unit_y;
        vec_pkg::vec3_t neg_a;
        vec_pkg::vec3_t neg_b;
        vec_pkg::vec3_t min_vec;
        vec_pkg::vec3_t max_vec;
        zero = make_vec('0, '0, '0);
        unit_x = make_vec(ONE, '0, '0);
        unit_y = make_vec('0, ONE, '0);
        // -1.5, -2.25, -3.0 and -0.5, -4.0, -1.25
        neg_a = make_vec(-32'sd98304, -32'sd147456, -32'sd196608);
        neg_b = make_vec(-32'sd32768, -32'sd262144, -32'sd81920);
        min_vec = make_vec(MOST_NEG, MOST_NEG, MOST_NEG);
        max_vec = make_vec(MOST_POS, MOST_NEG, ONE);
        check_edge_pair(zero, zero);
        check_edge_pair(unit_x, unit_y);
        check_edge_pair(unit_y, unit_y);
        check_edge_pair(neg_a, neg_b);
        check_edge_pair(min_vec, min_vec);
        check_edge_pair(min_vec, unit_x);
        check_edge_pair(min_vec, make_vec(-ONE, ONE, -ONE));
        check_edge_pair(max_vec, min_vec);
    endtask

    task automatic backpressure_test();
        vec_pkg::vec_cmd_t cmd;
        int accepted;
        int popped;
        int waited;
        int idle;
        int gap;
        accepted = 0;
        popped = 0;
        waited = 0;
        idle = 0;
        // back to back writes with no reads until the unit pushes back
        while (!cmd_full && waited < TIMEOUT_CYCLES) begin
            cmd = make_cmd(random_op(), full_vec(), full_vec());
            cmd_in = cmd;
            cmd_wr_en = 1'b1;
            expected_q.push_back(model_result(cmd));
            accepted++;
            @(negedge clock);
            waited++;
        end
        cmd_wr_en = 1'b0;
        if (!cmd_full) begin
            $display("timeout while filling, cmd_full never went high");
            error_count++;
            timed_out = 1'b1;
        end
        // drain with random gaps until the output stays empty
        waited = 0;
        while (idle < DRAIN_IDLE_CYCLES && waited < TIMEOUT_CYCLES && !timed_out) begin
            gap = $urandom_range(3, 0);
            repeat (gap) @(negedge clock);
            if (result_empty) begin
                @(negedge clock);
                idle++;
            end else begin
                idle = 0;
                read_result();
                popped++;
            end
            waited++;
        end
        if (idle < DRAIN_IDLE_CYCLES && !timed_out) begin
            $display("timeout while draining, results never stopped coming");
            error_count++;
            timed_out = 1'b1;
        end
        check_count++;
        assert (popped == accepted) else begin
            $display("drained %0d results after %0d accepted writes", popped, accepted);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    initial begin
        int errors_before;
        int i;
        void'($urandom(32'h06a76a73));
        clock = 1'b0;
        reset = 1'b1;
        cmd_in = '0;
        cmd_wr_en = 1'b0;
        result_rd_en = 1'b0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        failed_tests = 0;
        timed_out = 1'b0;

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        errors_before = error_count;
        @(negedge clock);
        check_count += 2;
        assert (result_empty == 1'b1) else begin
            $display("Fail result_empty got %h expected %h", result_empty, 1'b1);
            error_count++;
        end
        assert (cmd_full == 1'b0) else begin
            $display("Fail cmd_full got %h expected %h", cmd_full, 1'b0);
            error_count++;
        end
        report_test("reset state", errors_before);

        errors_before = error_count;
        for (i = 0; i < RANDOM_COUNT && !timed_out; i++) begin
            write_and_check(make_cmd(vec_pkg::OP_DOT, small_vec(), small_vec()));
        end
        report_test("dot products", errors_before);

        errors_before = error_count;
        for (i = 0; i < RANDOM_COUNT && !timed_out; i++) begin
            write_and_check(make_cmd(vec_pkg::OP_CROSS, full_vec(), full_vec()));
        end
        report_test("cross products", errors_before);

        errors_before = error_count;
        edge_value_test();
        report_test("edge values", errors_before);

        errors_before = error_count;
        if (!timed_out) begin
            backpressure_test();
        end
        report_test("back-pressure and order", errors_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/vec_pkg.sv
rtl/fifo.sv
rtl/vec_dot.sv
rtl/vec_cross.sv
rtl/vec_control.sv
rtl/vec_unit.sv
testbench/vec_unit_asserts.sv
testbench/vec_unit_tb.sv

//--- Makefile
# Verilator build and run for the vector unit testbench

VERILATOR  ?= verilator
TOP        ?= vec_unit_tb
RTL_TOP    ?= vec_unit
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= All tests passed!

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

lint-rtl:
	$(VERILATOR) --lint-only -Wall rtl/vec_pkg.sv rtl/fifo.sv rtl/vec_dot.sv \
		rtl/vec_cross.sv rtl/vec_control.sv rtl/vec_unit.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
